// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_stage_tb
RTL_TOP   ?= fetch_stage
FILELIST  ?= wisc_fetch.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Test OK
VFLAGS    ?= --timing --assert
JOBS      ?= 0
RTL_FILES ?= $(filter-out verif/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/wisc_pkg.sv ====
// Shared widths, opcode constants, stall lengths and instruction views for the wisc fetch stage
package wisc_pkg;

   ////////////////////
   // Widths
   ////////////////////

   // Instruction word and program counter
   localparam int word_w = 16;
   // Register file index, eight registers
   localparam int reg_w = 3;
   // Opcode field at the top of every word
   localparam int opcode_w = 5;
   // Instruction memory word address, 256 words
   localparam int imem_addr_w = 8;

   ////////////////////
   // Opcodes
   ////////////////////

   // Halt stops fetch and later triggers the memory dump
   localparam logic [opcode_w-1:0] op_halt = 5'b00000;

   // Three-bit opcode prefixes for control transfer
   localparam logic [2:0] jump_class = 3'b001;
   localparam logic [2:0] branch_class = 3'b011;

   // Bubble sent down the pipe on a hazard
   localparam logic [word_w-1:0] nop_word = 16'h0800;

   ////////////////////
   // Stall lengths
   ////////////////////

   // PC hold cycles after a jump leaves fetch
   localparam int jump_shadow = 4;
   // PC hold cycles after a branch leaves fetch
   localparam int branch_shadow = 2;
   // Halt fetch to dump pulse
   localparam int halt_delay = 5;
   // Destinations remembered by the hazard detector
   localparam int raw_depth = 3;

   ////////////////////
   // Instruction views
   ////////////////////

   // Register format, R-type ALU ops and register jumps
   typedef struct packed {
      logic [opcode_w-1:0] opcode;
      logic [reg_w-1:0]    rs;
      logic [reg_w-1:0]    rt;
      logic [reg_w-1:0]    rd;
      logic [1:0]          func;
   } reg_form_t;

   // Immediate format, 8-bit immediate after rs
   typedef struct packed {
      logic [opcode_w-1:0] opcode;
      logic [reg_w-1:0]    rs;
      logic [7:0]          imm;
   } imm_form_t;

   // Same 16 bits, decoded either way
   typedef union packed {
      reg_form_t reg_form;
      imm_form_t imm_form;
   } instr_word_t;

endpackage

// ==== fetch/fetch_stage.sv ====
// Fetch stage top: PC register, next-PC select, pipe registers and fetch sub-blocks
module fetch_stage (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        pc_src,
   input  logic [wisc_pkg::word_w-1:0] jump_pc,
   input  logic [wisc_pkg::reg_w-1:0]  dst,
   input  logic                        dst_valid,
   input  logic                        load_en,
   input  logic [wisc_pkg::imem_addr_w-1:0] load_addr,
   input  logic [wisc_pkg::word_w-1:0] load_data,
   output logic [wisc_pkg::word_w-1:0] instruction_out,
   output logic [wisc_pkg::word_w-1:0] incr_pc,
   output logic                        dump
);

   // Program counter, byte addressed
   logic [wisc_pkg::word_w-1:0] pc_q;
   logic [wisc_pkg::word_w-1:0] pc_plus2;
   logic [wisc_pkg::word_w-1:0] next_pc;

   // Fetched word and its pre-decode
   logic [wisc_pkg::word_w-1:0] instr;
   logic                        is_halt;
   logic                        is_jump;
   logic                        is_branch;
   logic [wisc_pkg::reg_w-1:0]  rs;
   logic [wisc_pkg::reg_w-1:0]  rt;
   logic                        rs_valid;
   logic                        rt_valid;

   // Stall signals
   logic raw;
   logic hold_pc;
   logic halted;

   ////////////////////
   // PC
   ////////////////////

   assign pc_plus2 = pc_q + 16'd2;

   // Redirect wins over sequential fetch
   assign next_pc = pc_src ? jump_pc : pc_plus2;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= '0;
      end else if (pc_src || !hold_pc) begin
         // A redirect always lands, even while stalled
         pc_q <= next_pc;
      end
   end

   ////////////////////
   // Sub-blocks
   ////////////////////

   // Word address is the byte PC without bit 0
   instr_memory instr_memory_i (
      .clk       (clk),
      .read_en   (!halted),
      .addr      (pc_q[wisc_pkg::imem_addr_w:1]),
      .instr     (instr),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

   predecode predecode_i (
      .instr     (instr),
      .is_halt   (is_halt),
      .is_jump   (is_jump),
      .is_branch (is_branch),
      .rs        (rs),
      .rt        (rt),
      .rs_valid  (rs_valid),
      .rt_valid  (rt_valid)
   );

   raw_detector raw_detector_i (
      .clk       (clk),
      .reset     (reset),
      .rs        (rs),
      .rt        (rt),
      .rs_valid  (rs_valid),
      .rt_valid  (rt_valid),
      .dst       (dst),
      .dst_valid (dst_valid),
      .raw       (raw)
   );

   stall_control stall_control_i (
      .clk       (clk),
      .reset     (reset),
      .is_halt   (is_halt),
      .is_jump   (is_jump),
      .is_branch (is_branch),
      .raw       (raw),
      .hold_pc   (hold_pc),
      .halted    (halted),
      .dump      (dump)
   );

   ////////////////////
   // Pipe registers
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         instruction_out <= '0;
         incr_pc         <= '0;
      end else begin
         // Bubble replaces the word on a hazard
         instruction_out <= raw ? wisc_pkg::nop_word : instr;
         incr_pc         <= pc_plus2;
      end
   end

   // Redirect targets keep the PC word aligned
   pc_even_a : assert property (@(posedge clk) disable iff (reset) !pc_q[0]);

   // Program load only while reset, memory not yet reading a live program
   load_idle_a : assert property (@(posedge clk) disable iff (reset) !(load_en && !halted));

endmodule

// ==== fetch/instr_memory.sv ====
// Instruction memory: 256 words, asynchronous read, synchronous load port
module instr_memory (
   input  logic                             clk,
   input  logic                             read_en,
   input  logic [wisc_pkg::imem_addr_w-1:0] addr,
   output logic [wisc_pkg::word_w-1:0]      instr,
   input  logic                             load_en,
   input  logic [wisc_pkg::imem_addr_w-1:0] load_addr,
   input  logic [wisc_pkg::word_w-1:0]      load_data
);

   // Word storage
   logic [wisc_pkg::word_w-1:0] mem [2**wisc_pkg::imem_addr_w];

   // Last word seen on the read port
   logic [wisc_pkg::word_w-1:0] last_word;

   ////////////////////
   // Write and capture
   ////////////////////

   always_ff @(posedge clk) begin
      // One program word per cycle
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
      // Remember the word so a frozen fetch stays stable
      if (read_en) begin
         last_word <= mem[addr];
      end
   end

   ////////////////////
   // Read
   ////////////////////

   // Live read, or the held word once reads stop
   always_comb begin
      if (read_en) begin
         instr = mem[addr];
      end else begin
         instr = last_word;
      end
   end

endmodule

// ==== fetch/predecode.sv ====
// Pre-decode: flags halt, jump and branch words and finds active source registers
module predecode (
   input  wisc_pkg::instr_word_t       instr,
   output logic                        is_halt,
   output logic                        is_jump,
   output logic                        is_branch,
   output logic [wisc_pkg::reg_w-1:0]  rs,
   output logic [wisc_pkg::reg_w-1:0]  rt,
   output logic                        rs_valid,
   output logic                        rt_valid
);

   // Opcode, same position in both views
   logic [wisc_pkg::opcode_w-1:0] opcode;
   // Top three opcode bits, the instruction class
   logic [2:0] op_class;

   assign opcode   = instr.reg_form.opcode;
   assign op_class = opcode[wisc_pkg::opcode_w-1 -: 3];

   ////////////////////
   // Control class
   ////////////////////

   assign is_halt   = (opcode == wisc_pkg::op_halt);
   assign is_jump   = (op_class == wisc_pkg::jump_class);
   assign is_branch = (op_class == wisc_pkg::branch_class);

   ////////////////////
   // Source registers
   ////////////////////

   // Field positions come from the register view
   assign rs = instr.reg_form.rs;
   assign rt = instr.reg_form.rt;

   // rs unused by the 000 class (halt, nop, return)
   // and by the direct jumps, class 001 with bit 11 clear
   always_comb begin
      rs_valid = 1'b1;
      if (op_class == 3'b000) begin
         rs_valid = 1'b0;
      end else if ({op_class, opcode[0]} == 4'b0010) begin
         rs_valid = 1'b0;
      end
   end

   // rt read by 1101 register ops and by the 111 ALU and compare group
   always_comb begin
      rt_valid = 1'b0;
      if (opcode[4:1] == 4'b1101) begin
         rt_valid = 1'b1;
      end
      if (op_class == 3'b111) begin
         rt_valid = 1'b1;
      end
   end

endmodule

// ==== fetch/stall_control.sv ====
// Stall control: jump, branch and halt shadows producing the PC hold and the dump pulse
module stall_control (
   input  logic clk,
   input  logic reset,
   input  logic is_halt,
   input  logic is_jump,
   input  logic is_branch,
   input  logic raw,
   output logic hold_pc,
   output logic halted,
   output logic dump
);

   // Shadow shift registers, bit 0 is the newest
   logic [wisc_pkg::jump_shadow-1:0]   jump_sr;
   logic [wisc_pkg::branch_shadow-1:0] branch_sr;
   logic [wisc_pkg::halt_delay-1:0]    halt_line;

   // Any control shadow still running
   logic shadow_busy;
   // Qualified control transfers entering a shadow
   logic jump_go;
   logic branch_go;

   assign shadow_busy = (|jump_sr) || (|branch_sr);

   // A stalled or re-fetched word must not start a second shadow
   assign jump_go   = is_jump && !raw && !shadow_busy;
   assign branch_go = is_branch && !raw && !shadow_busy;

   ////////////////////
   // Shadows
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         jump_sr   <= '0;
         branch_sr <= '0;
         halt_line <= '0;
         halted    <= 1'b0;
      end else begin
         jump_sr   <= {jump_sr[wisc_pkg::jump_shadow-2:0], jump_go};
         branch_sr <= {branch_sr[wisc_pkg::branch_shadow-2:0], branch_go};
         // Keep feeding ones once halted so dump stays up
         halt_line <= {halt_line[wisc_pkg::halt_delay-2:0], is_halt || halted};
         // Sticky until reset
         if (is_halt) begin
            halted <= 1'b1;
         end
      end
   end

   ////////////////////
   // Outputs
   ////////////////////

   // Halt freezes the PC in its own fetch cycle too
   assign hold_pc = raw || shadow_busy || halted || is_halt;

   // Dump after the full halt delay
   assign dump = halt_line[wisc_pkg::halt_delay-1];

   // Dump only ever follows a recorded halt
   dump_after_halt_a : assert property (@(posedge clk) disable iff (reset) dump |-> halted);

endmodule

// ==== source/raw_detector.sv ====
// RAW hazard detector matching active sources against a history of recent destinations
module raw_detector (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [wisc_pkg::reg_w-1:0] rs,
   input  logic [wisc_pkg::reg_w-1:0] rt,
   input  logic                       rs_valid,
   input  logic                       rt_valid,
   input  logic [wisc_pkg::reg_w-1:0] dst,
   input  logic                       dst_valid,
   output logic                       raw
);

   // Destination history with entry 0 newest
   logic [wisc_pkg::reg_w-1:0]     hist_dst [wisc_pkg::raw_depth];
   logic [wisc_pkg::raw_depth-1:0] hist_valid;

   ////////////////////
   // History
   ////////////////////

   // Destination indices shift in every cycle
   always_ff @(posedge clk) begin
      hist_dst[0] <= dst;
      for (int i = 1; i < wisc_pkg::raw_depth; i++) begin
         hist_dst[i] <= hist_dst[i-1];
      end
   end

   // Valid bits empty the history on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         hist_valid <= '0;
      end else begin
         hist_valid <= {hist_valid[wisc_pkg::raw_depth-2:0], dst_valid};
      end
   end

   ////////////////////
   // Match
   ////////////////////

   always_comb begin
      raw = 1'b0;
      for (int i = 0; i < wisc_pkg::raw_depth; i++) begin
         // Source reads a register still being written
         if (hist_valid[i] && rs_valid && (hist_dst[i] == rs)) begin
            raw = 1'b1;
         end
         if (hist_valid[i] && rt_valid && (hist_dst[i] == rt)) begin
            raw = 1'b1;
         end
      end
   end

   // Hazard needs a source flagged by pre-decode
   raw_has_source_a : assert property (@(posedge clk) disable iff (reset)
      raw |-> (rs_valid || rt_valid));

endmodule

// ==== verif/fetch_stage_tb.sv ====
// Fetch stage testbench: program load, file-driven cycles, output checks and watchdog
module fetch_stage_tb;

   // DUT ports
   logic                             clk;
   logic                             reset;
   logic                             pc_src;
   logic [wisc_pkg::word_w-1:0]      jump_pc;
   logic [wisc_pkg::reg_w-1:0]       dst;
   logic                             dst_valid;
   logic                             load_en;
   logic [wisc_pkg::imem_addr_w-1:0] load_addr;
   logic [wisc_pkg::word_w-1:0]      load_data;
   logic [wisc_pkg::word_w-1:0]      instruction_out;
   logic [wisc_pkg::word_w-1:0]      incr_pc;
   logic                             dump;

   // Program words, loaded one per reset cycle
   logic [wisc_pkg::imem_addr_w-1:0] prog_addr [$];
   logic [wisc_pkg::word_w-1:0]      prog_data [$];

   // Outputs expected while reset is high
   logic [wisc_pkg::word_w-1:0] reset_instr;
   logic [wisc_pkg::word_w-1:0] reset_incr;
   logic                        reset_dump;
   string                       reset_name;

   // One entry per cycle after reset
   logic                        cyc_pc_src [$];
   logic [wisc_pkg::word_w-1:0] cyc_jump_pc [$];
   logic [wisc_pkg::reg_w-1:0]  cyc_dst [$];
   logic                        cyc_dst_valid [$];
   logic [wisc_pkg::word_w-1:0] cyc_instr [$];
   logic [wisc_pkg::word_w-1:0] cyc_incr [$];
   logic                        cyc_dump [$];
   string                       cyc_name [$];

   // Bookkeeping
   bit    stim_ready;
   string test_name;
   int    test_checks;
   int    test_errors;
   int    tests_passed;
   int    tests_failed;
   int    checks_total;
   int    file_errors;

   fetch_stage fetch_stage_i (
      .clk             (clk),
      .reset           (reset),
      .pc_src          (pc_src),
      .jump_pc         (jump_pc),
      .dst             (dst),
      .dst_valid       (dst_valid),
      .load_en         (load_en),
      .load_addr       (load_addr),
      .load_data       (load_data),
      .instruction_out (instruction_out),
      .incr_pc         (incr_pc),
      .dump            (dump)
   );

   // Starts high, so the first falling edge comes before any rising edge
   always #5 clk = ~clk;

   ////////////////////
   // Stimulus file
   ////////////////////

   task automatic read_stimulus();
      int                               fd;
      int                               n;
      string                            line;
      byte                              kind;
      logic [wisc_pkg::imem_addr_w-1:0] a;
      logic [wisc_pkg::word_w-1:0]      d;
      logic                             p;
      logic [wisc_pkg::word_w-1:0]      j;
      logic [wisc_pkg::reg_w-1:0]       r;
      logic                             v;
      logic [wisc_pkg::word_w-1:0]      ei;
      logic [wisc_pkg::word_w-1:0]      ep;
      logic                             ed;
      string                            nm;
      fd = $fopen("verif/fetch_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file verif/fetch_stimulus.txt");
         file_errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         // Drop the line end
         if (line.len() > 0 && line.getc(line.len() - 1) == "\n") begin
            line = line.substr(0, line.len() - 2);
         end
         kind = line.getc(0);
         if (kind == "L") begin
            n = $sscanf(line, "L %h %h", a, d);
            if (n == 2) begin
               prog_addr.push_back(a);
               prog_data.push_back(d);
            end else begin
               $display("Stimulus line not understood: %s", line);
               file_errors++;
            end
         end else if (kind == "R") begin
            n = $sscanf(line, "R %h %h %h %s", ei, ep, ed, nm);
            if (n == 4) begin
               reset_instr = ei;
               reset_incr  = ep;
               reset_dump  = ed;
               reset_name  = nm;
            end else begin
               $display("Stimulus line not understood: %s", line);
               file_errors++;
            end
         end else if (kind == "C") begin
            n = $sscanf(line, "C %h %h %h %h %h %h %h %s", p, j, r, v, ei, ep, ed, nm);
            if (n == 8) begin
               cyc_pc_src.push_back(p);
               cyc_jump_pc.push_back(j);
               cyc_dst.push_back(r);
               cyc_dst_valid.push_back(v);
               cyc_instr.push_back(ei);
               cyc_incr.push_back(ep);
               cyc_dump.push_back(ed);
               cyc_name.push_back(nm);
            end else begin
               $display("Stimulus line not understood: %s", line);
               file_errors++;
            end
         end
         // Comments and blank lines fall through
      end
      $fclose(fd);
   endtask

   // Later-stage inputs for one cycle
   task automatic drive_cycle(input int k);
      pc_src    = cyc_pc_src[k];
      jump_pc   = cyc_jump_pc[k];
      dst       = cyc_dst[k];
      dst_valid = cyc_dst_valid[k];
   endtask

   ////////////////////
   // Checks
   ////////////////////

   // Opcode, rs and immediate through the immediate view
   function automatic string describe_word(input wisc_pkg::instr_word_t w);
      return $sformatf("%h (op %b rs %0d imm %h)", w, w.imm_form.opcode, w.imm_form.rs,
                       w.imm_form.imm);
   endfunction

   task automatic check_word(input string what, input logic [wisc_pkg::word_w-1:0] expected,
                             input logic [wisc_pkg::word_w-1:0] actual, input bit as_instr);
      checks_total++;
      test_checks++;
      if (actual !== expected) begin
         test_errors++;
         if (as_instr) begin
            $display("** Error %s: %s expected %s actual %s", test_name, what,
                     describe_word(expected), describe_word(actual));
         end else begin
            $display("** Error %s: %s expected %h actual %h", test_name, what, expected, actual);
         end
      end
   endtask

   task automatic check_bit(input string what, input logic expected, input logic actual);
      checks_total++;
      test_checks++;
      if (actual !== expected) begin
         test_errors++;
         $display("** Error %s: %s expected %b actual %b", test_name, what, expected, actual);
      end
   endtask

   // One line per finished test
   task automatic close_test();
      if (test_checks > 0) begin
         if (test_errors == 0) begin
            tests_passed++;
            $display("passed %s (%0d checks)", test_name, test_checks);
         end else begin
            tests_failed++;
            $display("failed %s (%0d of %0d checks wrong)", test_name, test_errors, test_checks);
         end
      end
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic start_test(input string name);
      if (name != test_name) begin
         close_test();
         test_name = name;
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      clk          = 1'b1;
      reset        = 1'b1;
      pc_src       = 1'b0;
      jump_pc      = '0;
      dst          = '0;
      dst_valid    = 1'b0;
      load_en      = 1'b0;
      load_addr    = '0;
      load_data    = '0;
      test_name    = "";
      test_checks  = 0;
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      checks_total = 0;
      file_errors  = 0;
      read_stimulus();
      if (prog_addr.size() > 10) begin
         $display("Program has %0d words, more than ten reset cycles can load", prog_addr.size());
         file_errors++;
      end
      if (cyc_name.size() == 0) begin
         $display("Stimulus file holds no cycle lines");
         file_errors++;
      end
      stim_ready = 1'b1;
      // Ten reset cycles, program load on the way
      for (int i = 0; i <= 10; i++) begin
         @(negedge clk);
         if (i > 0) begin
            start_test(reset_name);
            check_word("instruction_out", reset_instr, instruction_out, 1'b1);
            check_word("incr_pc", reset_incr, incr_pc, 1'b0);
            check_bit("dump", reset_dump, dump);
         end
         if (i < 10 && i < prog_addr.size()) begin
            load_en   = 1'b1;
            load_addr = prog_addr[i];
            load_data = prog_data[i];
         end else begin
            load_en = 1'b0;
         end
      end
      reset = 1'b0;
      if (cyc_name.size() > 0) begin
         drive_cycle(0);
      end
      // Each line checked one rising edge after it was driven
      for (int k = 0; k < cyc_name.size(); k++) begin
         @(negedge clk);
         start_test(cyc_name[k]);
         check_word("instruction_out", cyc_instr[k], instruction_out, 1'b1);
         check_word("incr_pc", cyc_incr[k], incr_pc, 1'b0);
         check_bit("dump", cyc_dump[k], dump);
         if (k + 1 < cyc_name.size()) begin
            drive_cycle(k + 1);
         end else begin
            pc_src    = 1'b0;
            dst_valid = 1'b0;
         end
      end
      close_test();
      $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d stimulus errors",
               tests_passed, tests_failed, checks_total, file_errors);
      if (tests_failed == 0 && file_errors == 0 && tests_passed > 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog, sized from the number of cycle lines
   initial begin
      wait (stim_ready);
      #((cyc_name.size() + 20) * 10);
      $display("Watchdog expired: the run did not finish within %0d cycles",
               cyc_name.size() + 20);
      $display("Test FAILED");
      $finish;
   end

endmodule

// ==== verif/fetch_stimulus.txt ====
# L word_addr data: program word loaded while reset is high
# R instruction_out incr_pc dump name: outputs expected during reset
# C pc_src jump_pc dst dst_valid instruction_out incr_pc dump name: one cycle after reset
L 00 d94c
L 01 4405
L 02 8510
L 03 4b01
L 04 2006
L 05 9a20
L 06 e0e4
L 07 6602
L 08 4703
L 09 0000
R 0000 0000 0 reset_state
# sequential fetch, no destinations reported
C 0 0000 0 0 d94c 0002 0 seq_fetch
C 0 0000 0 0 4405 0004 0 seq_fetch
# r3 reported, read by the word at 0x06, bubbles until it leaves the history
C 0 0000 3 1 8510 0006 0 hazard_bubble
C 0 0000 0 0 0800 0008 0 hazard_bubble
C 0 0000 0 0 0800 0008 0 hazard_bubble
C 0 0000 0 0 0800 0008 0 hazard_bubble
C 0 0000 0 0 4b01 0008 0 hazard_bubble
# jump at 0x08, PC held at 0x0a for four cycles, redirect in the last one
C 0 0000 0 0 2006 000a 0 jump_shadow
C 0 0000 0 0 9a20 000c 0 jump_shadow
C 0 0000 0 0 9a20 000c 0 jump_shadow
C 0 0000 0 0 9a20 000c 0 jump_shadow
C 1 000e 0 0 9a20 000c 0 jump_shadow
# redirect lands on the branch at 0x0e
C 0 0000 0 0 6602 0010 0 jump_redirect
# branch shadow, PC held at 0x10 for two cycles, then on to 0x12
C 0 0000 0 0 4703 0012 0 branch_shadow
C 0 0000 0 0 4703 0012 0 branch_shadow
C 0 0000 0 0 4703 0012 0 branch_shadow
# halt at 0x12, dump on the fifth edge after the fetch
C 0 0000 0 0 0000 0014 0 halt_dump
C 0 0000 0 0 0000 0014 0 halt_dump
C 0 0000 0 0 0000 0014 0 halt_dump
C 0 0000 0 0 0000 0014 0 halt_dump
C 0 0000 0 0 0000 0014 1 halt_dump
C 0 0000 0 0 0000 0014 1 halt_dump
C 0 0000 0 0 0000 0014 1 halt_dump

// ==== wisc_fetch.f ====
common/wisc_pkg.sv
source/raw_detector.sv
fetch/instr_memory.sv
fetch/predecode.sv
fetch/stall_control.sv
fetch/fetch_stage.sv
verif/fetch_stage_tb.sv
